// File: logic/flash_pkg.sv
// Definitions shared by the cache and the SPI engine of the XIP read path
// Flash addresses are 24 bits wide; only Fast Read with 8 dummy clocks is used

`default_nettype none

package flash_pkg;

    // Data word as seen by the requester, or raw as shifted in from the bus
    typedef logic [31:0] flash_word_t;

    // Byte address as sent to the flash
    typedef logic [23:0] flash_addr_t;

    localparam logic [7:0] FLASH_CMD_FAST_READ = 8'h0B;
    localparam int FLASH_DUMMY_CYCLES = 8;          // Clocks between address and data

    // Miss request from the cache to the engine
    typedef struct packed {
        flash_addr_t addr;
    } flash_rd_req_t;

    // Raw fill word in shift order
    typedef struct packed {
        flash_word_t data;                          // First received byte sits in bits 31:24
    } flash_rd_rsp_t;

endpackage

`default_nettype wire

// File: logic/flash_word_cache.sv
// One-word read cache in front of the SPI engine with all state on the falling edge
// Only address bits 23:0 form the tag, so addresses alias every 16 MiB
// A request dropped during a fill completes the fill but returns no data

`timescale 1ns/1ps
`default_nettype none

module flash_word_cache (
    input  wire                      i_clock,
    input  wire                      i_reset,
    input  wire                      i_request,
    input  wire flash_pkg::flash_word_t   i_address,
    output flash_pkg::flash_word_t   o_rdata,
    output logic                     o_ready,
    output flash_pkg::flash_rd_req_t o_miss_req,
    output logic                     o_miss_valid,
    input  wire flash_pkg::flash_rd_rsp_t i_fill_rsp,
    input  wire                      i_fill_done
);

    typedef enum logic [1:0] {
        IDLE,
        LOOKUP,
        FILL,
        HOLD
    } state_t;

    state_t                 state;
    logic                   cache_valid;
    logic                   req_dropped;        // Requester gave up while the fill was running
    flash_pkg::flash_addr_t cache_tag;
    flash_pkg::flash_word_t cache_data;
    flash_pkg::flash_addr_t req_addr;
    flash_pkg::flash_word_t fill_word;
    logic                   hit;

    assign req_addr = i_address[23:0];          // Upper 8 bits never reach the flash
    assign hit      = cache_valid && (cache_tag == req_addr);

    // The first byte off the bus belongs at the requested address, so it goes to bits 7:0
    assign fill_word = {i_fill_rsp.data[7:0],   i_fill_rsp.data[15:8],
                        i_fill_rsp.data[23:16], i_fill_rsp.data[31:24]};

    assign o_rdata = cache_data;                // Valid whenever o_ready is high

    always_ff @(negedge i_clock) begin
        if (i_reset) begin
            state        <= IDLE;
            o_ready      <= 1'b0;
            o_miss_valid <= 1'b0;
            cache_valid  <= 1'b0;
            req_dropped  <= 1'b0;
        end else begin
            case (state)
                IDLE: begin
                    if (i_request) begin
                        state <= LOOKUP;
                    end
                end

                LOOKUP: begin
                    if (!i_request) begin
                        state <= IDLE;
                    end else if (hit) begin
                        o_ready <= 1'b1;
                        state   <= HOLD;
                    end else begin
                        o_miss_valid <= 1'b1;       // Address in o_miss_req is loaded alongside
                        req_dropped  <= 1'b0;
                        state        <= FILL;
                    end
                end

                FILL: begin
                    if (!i_request) begin
                        req_dropped <= 1'b1;
                    end
                    if (i_fill_done) begin
                        o_miss_valid <= 1'b0;
                        cache_valid  <= 1'b1;
                        if (i_request && !req_dropped) begin
                            o_ready <= 1'b1;
                            state   <= HOLD;
                        end else begin
                            state <= IDLE;          // A new request starts over with a lookup
                        end
                    end
                end

                HOLD: begin
                    o_ready <= i_request;           // Held for as long as the requester holds
                    if (!i_request) begin
                        state <= IDLE;
                    end
                end

                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

    // Forwarded miss address, and the cached word with its tag
    always_ff @(negedge i_clock) begin
        if (state == LOOKUP && i_request && !hit) begin
            o_miss_req.addr <= req_addr;
        end
        if (state == FILL && i_fill_done) begin
            cache_tag  <= o_miss_req.addr;          // The sent address outlives a departed requester
            cache_data <= fill_word;
        end
    end

    // A miss only starts after the previous answer has been withdrawn
    assert property (@(negedge i_clock) disable iff (i_reset)
        $rose(o_miss_valid) |-> !o_ready && !$past(o_ready))
        else $error("miss_valid rose while o_ready was high");

endmodule

`default_nettype wire

// File: logic/flash_spi_engine.sv
// SPI Fast Read engine for serial NOR flash with state changes on the falling edge
// The SPI clock is i_clock gated by chip select, so FREQUENCY must not exceed 104 MHz
// One read of 32 bits per miss without writes, status polling or multi-lane modes

`timescale 1ns/1ps
`default_nettype none

module flash_spi_engine #(
    parameter int unsigned FREQUENCY = 100_000_000
) (
    input  wire                      i_clock,
    input  wire                      i_reset,
    input  wire flash_pkg::flash_rd_req_t i_miss_req,
    input  wire                      i_miss_valid,
    output flash_pkg::flash_rd_rsp_t o_fill_rsp,
    output logic                     o_fill_done,
    output logic                     o_spi_ncs,
    output logic                     o_spi_clk,
    output logic                     o_spi_mosi,
    input  wire                      i_spi_miso
);

    typedef enum logic [1:0] {
        IDLE,
        SEND_CMD,
        RECV_DAT,
        DONE
    } state_t;

    // Command, address and dummy clocks run back to back in SEND_CMD
    localparam logic [5:0] SEND_LAST = 6'(32 + flash_pkg::FLASH_DUMMY_CYCLES - 1);
    localparam logic [5:0] RECV_LAST = 6'd31;

    if (FREQUENCY > 104_000_000) begin : g_spi_clock_check
        $error("flash_spi_engine: FREQUENCY %0d Hz exceeds the 104 MHz Fast Read limit",
               FREQUENCY);
    end

    state_t                 state;
    logic [5:0]             count;
    logic [31:0]            shifter;            // Command byte and address in MSB-first order
    flash_pkg::flash_word_t rx_word;

    assign o_spi_clk  = !o_spi_ncs && i_clock;  // Flash sees rising edges mid-cycle
    assign o_spi_mosi = shifter[31];
    assign o_fill_rsp = '{data: rx_word};

    always_ff @(negedge i_clock) begin
        if (i_reset) begin
            state       <= IDLE;
            count       <= '0;
            o_spi_ncs   <= 1'b1;
            o_fill_done <= 1'b0;
        end else begin
            o_fill_done <= 1'b0;

            case (state)
                IDLE: begin
                    if (i_miss_valid) begin
                        o_spi_ncs <= 1'b0;
                        count     <= '0;
                        state     <= SEND_CMD;
                    end
                end

                SEND_CMD: begin
                    count <= count + 6'd1;
                    if (count == SEND_LAST) begin
                        count <= '0;
                        state <= RECV_DAT;
                    end
                end

                RECV_DAT: begin
                    count <= count + 6'd1;
                    if (count == RECV_LAST) begin
                        o_spi_ncs   <= 1'b1;
                        o_fill_done <= 1'b1;
                        state       <= DONE;
                    end
                end

                DONE: begin
                    state <= IDLE;          // Cache drops miss_valid on this edge
                end

                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

    // Outgoing command and address, and the incoming data word
    always_ff @(negedge i_clock) begin
        case (state)
            IDLE: begin
                if (i_miss_valid) begin
                    shifter <= {flash_pkg::FLASH_CMD_FAST_READ, i_miss_req.addr};
                end
            end
            SEND_CMD: begin
                shifter <= {shifter[30:0], 1'b0};   // Zeros go out during the dummy clocks
            end
            RECV_DAT: begin
                rx_word <= {rx_word[30:0], i_spi_miso};
            end
            default: begin
                shifter <= shifter;
            end
        endcase
    end

    // Chip select is only active while a transfer is underway
    assert property (@(negedge i_clock) disable iff (i_reset)
        !o_spi_ncs |-> state != IDLE)
        else $error("o_spi_ncs low while the engine is idle");

    // The cache relies on a single-cycle completion pulse
    assert property (@(negedge i_clock) disable iff (i_reset)
        o_fill_done |=> !o_fill_done)
        else $error("o_fill_done high for two cycles");

endmodule

`default_nettype wire

// File: logic/flash_xip_reader.sv
// Memory-mapped read path for serial NOR flash: a one-word cache in front of Fast Read
// Requests are held levels; o_ready stays high while i_request is held after completion
// Address bits 31:24 are ignored

`timescale 1ns/1ps
`default_nettype none

module flash_xip_reader #(
    parameter int unsigned FREQUENCY = 100_000_000     // Rate of i_clock in Hz
) (
    input  wire                    i_clock,
    input  wire                    i_reset,
    input  wire                    i_request,
    input  wire flash_pkg::flash_word_t i_address,
    output flash_pkg::flash_word_t o_rdata,
    output logic                   o_ready,
    output logic                   o_spi_ncs,
    output logic                   o_spi_clk,
    output logic                   o_spi_mosi,
    input  wire                    i_spi_miso
);

    flash_pkg::flash_rd_req_t miss_req;
    logic                     miss_valid;
    flash_pkg::flash_rd_rsp_t fill_rsp;
    logic                     fill_done;

    flash_word_cache flash_word_cache_inst (
        .i_clock      (i_clock),
        .i_reset      (i_reset),
        .i_request    (i_request),
        .i_address    (i_address),
        .o_rdata      (o_rdata),
        .o_ready      (o_ready),
        .o_miss_req   (miss_req),
        .o_miss_valid (miss_valid),
        .i_fill_rsp   (fill_rsp),
        .i_fill_done  (fill_done)
    );

    flash_spi_engine #(
        .FREQUENCY (FREQUENCY)
    ) flash_spi_engine_inst (
        .i_clock      (i_clock),
        .i_reset      (i_reset),
        .i_miss_req   (miss_req),
        .i_miss_valid (miss_valid),
        .o_fill_rsp   (fill_rsp),
        .o_fill_done  (fill_done),
        .o_spi_ncs    (o_spi_ncs),
        .o_spi_clk    (o_spi_clk),
        .o_spi_mosi   (o_spi_mosi),
        .i_spi_miso   (i_spi_miso)
    );

endmodule

`default_nettype wire

// File: dv/spi_flash_model.sv
// Behavioral SPI NOR flash in mode 0 that answers Fast Read (0x0B) only
// Byte at address a is a[23:16] ^ a[15:8] ^ a[7:0] ^ 0x5A, addresses wrap at 16 MiB

`timescale 1ns/1ps
`default_nettype none

module spi_flash_model (
    input  wire         i_spi_ncs,
    input  wire         i_spi_clk,
    input  wire         i_spi_mosi,
    output logic        o_spi_miso,
    output logic [7:0]  o_last_cmd,
    output logic [23:0] o_last_addr,
    output int          o_txn_count
);

    logic [7:0]  cmd;
    logic [23:0] addr;
    int          edges = 0;                     // Rising SPI clocks in this transaction

    // Bit n of the data stream, each byte sent MSB first
    function automatic logic stream_bit(input logic [23:0] base, input int n);
        logic [23:0] a;
        logic [7:0]  b;
        a = base + 24'(n / 8);
        b = a[23:16] ^ a[15:8] ^ a[7:0] ^ 8'h5a;
        return b[7 - (n % 8)];
    endfunction

    initial begin
        o_spi_miso  = 1'b0;
        o_last_cmd  = '0;
        o_last_addr = '0;
        o_txn_count = 0;
    end

    always @(posedge i_spi_clk or posedge i_spi_ncs) begin
        if (i_spi_ncs) begin
            if (edges > 0) begin                // Ignore the release of chip select at reset
                if (cmd != 8'h0b) begin
                    $display("Flash model received unsupported command %h at %0t ns", cmd, $time);
                end
                o_last_cmd  <= cmd;
                o_last_addr <= addr;
                o_txn_count <= o_txn_count + 1;
            end
            edges <= 0;
        end else begin
            if (edges < 8) begin
                cmd <= {cmd[6:0], i_spi_mosi};
            end else if (edges < 32) begin
                addr <= {addr[22:0], i_spi_mosi};
            end
            edges <= edges + 1;
        end
    end

    // Data starts after the falling edge that ends the 8th dummy clock
    always @(negedge i_spi_clk) begin
        if (edges >= 40) begin
            o_spi_miso <= stream_bit(addr, edges - 40);
        end
    end

endmodule

`default_nettype wire

// File: dv/flash_xip_reader_tb.sv
// Testbench for the XIP read path against a behavioral flash
// The DUT changes state on the falling edge
// Inputs move and outputs are sampled on the rising edge

`timescale 1ns/1ps
`default_nettype none

module flash_xip_reader_tb;

    localparam int READY_TIMEOUT = 200;         // In cycles against a miss of about 75
    localparam int RANDOM_READS  = 20;

    logic                   i_clock = 1'b0;
    logic                   i_reset;
    logic                   i_request;
    flash_pkg::flash_word_t i_address;
    flash_pkg::flash_word_t o_rdata;
    logic                   o_ready;
    logic                   o_spi_ncs;
    logic                   o_spi_clk;
    logic                   o_spi_mosi;
    logic                   i_spi_miso;
    logic [7:0]             model_cmd;
    logic [23:0]            model_addr;
    int                     txn_count;
    logic                   seen_request = 1'b0;
    logic                   have_last = 1'b0;   // The cache holds last_low once a read completed
    logic [23:0]            last_low;
    int                     check_errors = 0;
    int                     assert_errors = 0;
    int                     timeouts = 0;

    always #4 i_clock = ~i_clock;

    flash_xip_reader flash_xip_reader_inst (
        .i_clock    (i_clock),
        .i_reset    (i_reset),
        .i_request  (i_request),
        .i_address  (i_address),
        .o_rdata    (o_rdata),
        .o_ready    (o_ready),
        .o_spi_ncs  (o_spi_ncs),
        .o_spi_clk  (o_spi_clk),
        .o_spi_mosi (o_spi_mosi),
        .i_spi_miso (i_spi_miso)
    );

    spi_flash_model spi_flash_model_inst (
        .i_spi_ncs   (o_spi_ncs),
        .i_spi_clk   (o_spi_clk),
        .i_spi_mosi  (o_spi_mosi),
        .o_spi_miso  (i_spi_miso),
        .o_last_cmd  (model_cmd),
        .o_last_addr (model_addr),
        .o_txn_count (txn_count)
    );

    // Nothing moves before the first request
    assert property (@(posedge i_clock) disable iff (i_reset)
        !seen_request |-> !o_ready && o_spi_ncs)
        else begin
            $display("CHECK FAILED at %0t ns: o_ready/o_spi_ncs expected 0/1, got %b/%b",
                     $time, o_ready, o_spi_ncs);
            assert_errors = assert_errors + 1;
        end

    assert property (@(posedge i_clock) disable iff (i_reset)
        $past(o_ready) && i_request |-> o_ready)
        else begin
            $display("CHECK FAILED at %0t ns: o_ready expected 1, got %b", $time, o_ready);
            assert_errors = assert_errors + 1;
        end

    assert property (@(posedge i_clock) disable iff (i_reset)
        $fell(i_request) |-> !o_ready)
        else begin
            $display("CHECK FAILED at %0t ns: o_ready expected 0, got %b", $time, o_ready);
            assert_errors = assert_errors + 1;
        end

    // The SPI clock only runs while chip select is low
    always @(posedge o_spi_clk) begin
        if (!i_reset) begin
            assert (!o_spi_ncs) else begin
                $display("CHECK FAILED at %0t ns: o_spi_ncs at SPI clock expected 0, got %b",
                         $time, o_spi_ncs);
                assert_errors = assert_errors + 1;
            end
        end
    end

    // Byte k is the content byte at the low 24 address bits plus k
    function automatic logic [31:0] expected_word(input logic [31:0] addr);
        logic [23:0] a;
        logic [31:0] word;
        for (int k = 0; k < 4; k++) begin
            a = addr[23:0] + 24'(k);
            word[8*k +: 8] = a[23:16] ^ a[15:8] ^ a[7:0] ^ 8'h5a;
        end
        return word;
    endfunction

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        assert (actual === expected) else begin
            $display("CHECK FAILED at %0t ns: %s expected %h, got %h",
                     $time, name, expected, actual);
            check_errors = check_errors + 1;
        end
    endtask

    task automatic do_read(input logic [31:0] addr, input int hold_cycles);
        logic [31:0] expected;
        logic        hit_expected;
        logic        bus_used;
        logic        done;
        int          n;
        int          txn_before;
        expected     = expected_word(addr);
        hit_expected = have_last && (addr[23:0] == last_low);
        txn_before   = txn_count;
        bus_used     = 1'b0;
        done         = 1'b0;
        n            = 0;
        i_request    <= 1'b1;
        i_address    <= addr;
        seen_request <= 1'b1;
        while (!done && n < READY_TIMEOUT) begin
            @(posedge i_clock);
            n        = n + 1;
            bus_used = bus_used || !o_spi_ncs;
            done     = o_ready;
        end
        if (!done) begin
            $display("Read of address %h never completed within %0d cycles", addr, READY_TIMEOUT);
            timeouts = timeouts + 1;
        end else begin
            check_value("o_rdata", expected, o_rdata);
            if (hit_expected) begin
                check_value("hit latency in cycles", 32'd2, 32'(n));
                check_value("o_spi_ncs low during hit", 32'd0, 32'(bus_used));
            end else begin
                check_value("flash command", 32'h0b, 32'(model_cmd));
                check_value("flash address", 32'(addr[23:0]), 32'(model_addr));
                check_value("flash transaction count", 32'(txn_before + 1), 32'(txn_count));
            end
            if (hold_cycles > 0) begin
                repeat (hold_cycles) @(posedge i_clock);
                check_value("o_rdata while held", expected, o_rdata);
            end
            have_last = 1'b1;
            last_low  = addr[23:0];
        end
        i_request <= 1'b0;
        n = 0;
        do begin
            @(posedge i_clock);
            n = n + 1;
        end while (o_ready && n < READY_TIMEOUT);
        if (o_ready) begin
            $display("o_ready never fell after i_request was dropped");
            timeouts = timeouts + 1;
        end
    endtask

    initial begin
        logic [31:0] addr;
        void'($urandom(32'h89a0));
        i_reset   = 1'b1;
        i_request = 1'b0;
        i_address = '0;
        repeat (4) @(posedge i_clock);
        i_reset <= 1'b0;
        repeat (3) @(posedge i_clock);
        addr = $urandom;
        do_read(addr, 0);                                   // Cold miss
        do_read(addr, 4);                                   // Hit that is held past completion
        do_read({addr[31:24] ^ 8'h3c, addr[23:0]}, 0);      // Alias in bits 31:24 hits too
        do_read({addr[31:24], addr[23:0] + 24'd4}, 2);      // Next word goes to the bus
        for (int i = 0; i < RANDOM_READS; i++) begin
            do_read($urandom, i % 3);
        end
        repeat (2) @(posedge i_clock);
        $display("Failed checks: %0d, failed assertions: %0d, timeouts: %0d",
                 check_errors, assert_errors, timeouts);
        if (check_errors + assert_errors + timeouts == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: flash_xip_reader.f
logic/flash_pkg.sv
logic/flash_word_cache.sv
logic/flash_spi_engine.sv
logic/flash_xip_reader.sv
dv/spi_flash_model.sv
dv/flash_xip_reader_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Builds the testbench with Verilator, runs it and scans the log for the failure line
set -eo pipefail
cd "$(dirname "$0")"

verilator --binary --timing --assert -f flash_xip_reader.f \
    --top-module flash_xip_reader_tb -o flash_xip_reader_sim
./obj_dir/flash_xip_reader_sim | tee sim.log

if grep -q '\*\* FAIL \*\*' sim.log; then
    echo "Simulation reported failure"
    exit 1
fi
echo "Simulation finished without failure"
